// ==== filelist.f ====
+incdir+verif
design/matmul_pkg.sv
design/matmul_ctrl.sv
design/matmul_addr_gen.sv
design/matmul_mac.sv
design/matmul_top.sv
verif/tb_matmul.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the matmul testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
  --top-module tb_matmul -f filelist.f -o sim_matmul

./obj_dir/sim_matmul > sim.log 2>&1
cat sim.log

if grep -qx "NO ERRORS" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

// ==== verif/matmul_tests.svh ====
//--------------------------------------------------------------------------
// Directed tests. Matrices are kept row-major here and load_job stores
// the weight matrix column by column in its SRAM
//--------------------------------------------------------------------------
`ifndef matmul_tests_svh
`define matmul_tests_svh

int    rows_r;
int    inner_k;
int    cols_c;
data_t a_elems [$];     // R x K
data_t b_elems [$];     // K x C
int    log_start;       // Log position when the current job started

task automatic value_mismatch(input string what, input int index,
                              input data_t expected, input data_t got);
  $display("[FAIL] t=%0t %s index %0d expected %h got %h", $time, what, index, expected, got);
  err_count++;
endtask

task automatic check_failed(input string msg);
  $display("[FAIL] t=%0t %s", $time, msg);
  err_count++;
endtask

// Sum over k of a[r][k] * b[k][c] modulo 2^32
function automatic data_t model_elem(input int r, input int c);
  data_t sum;
  sum = '0;
  for (int k = 0; k < inner_k; k++) begin
    sum = sum + a_elems[r * inner_k + k] * b_elems[k * cols_c + c];
  end
  return sum;
endfunction

task automatic random_operands(input int r, input int k, input int c);
  rows_r  = r;
  inner_k = k;
  cols_c  = c;
  a_elems.delete();
  b_elems.delete();
  repeat (r * k) a_elems.push_back($urandom());
  repeat (k * c) b_elems.push_back($urandom());
endtask

task automatic load_job();
  header_t hdr;
  @(negedge clk);                     // Away from the SRAM read edge
  hdr.dims.rows = 16'(rows_r);
  hdr.dims.cols = 16'(inner_k);
  input_mem[0] = hdr.raw;
  hdr.dims.rows = 16'(inner_k);
  hdr.dims.cols = 16'(cols_c);
  weight_mem[0] = hdr.raw;
  for (int i = 0; i < rows_r * inner_k; i++) begin
    input_mem[addr_t'(i + 1)] = a_elems[i];
  end
  for (int c = 0; c < cols_c; c++) begin
    for (int k = 0; k < inner_k; k++) begin
      weight_mem[addr_t'(1 + c * inner_k + k)] = b_elems[k * cols_c + c];
    end
  end
endtask

task automatic start_job();
  log_start = write_addr_log.size();
  @(posedge clk);
  dut_valid <= 1'b1;
  @(posedge clk);
  dut_valid <= 1'b0;
  @(negedge clk);
  if (dut_ready !== 1'b0) begin
    check_failed("dut_ready stayed high after dut_valid was sampled");
  end
endtask

task automatic wait_ready();
  while (dut_ready !== 1'b1) @(negedge clk);
endtask

task automatic compare_results(input string what);
  int n;
  n = rows_r * cols_c;
  if (write_addr_log.size() - log_start != n) begin
    value_mismatch({what, " write count"}, 0, n, write_addr_log.size() - log_start);
  end
  for (int i = 0; i < n && log_start + i < write_addr_log.size(); i++) begin
    if (write_addr_log[log_start + i] !== addr_t'(i)) begin
      value_mismatch({what, " write address"}, i, i, write_addr_log[log_start + i]);
    end
  end
  for (int r = 0; r < rows_r; r++) begin
    for (int c = 0; c < cols_c; c++) begin
      if (result_mem[addr_t'(r * cols_c + c)] !== model_elem(r, c)) begin
        value_mismatch(what, r * cols_c + c, model_elem(r, c),
                       result_mem[addr_t'(r * cols_c + c)]);
      end
    end
  end
endtask

//--------------------------------------------------------------------------
// Tests

task automatic idle_after_reset();
  repeat (6) begin
    @(negedge clk);
    if (dut_ready !== 1'b1 || sram_result_write_enable !== 1'b0) begin
      check_failed("DUT not idle after reset");
    end
  end
endtask

task automatic fixed_2x2_product();
  rows_r  = 2;
  inner_k = 2;
  cols_c  = 2;
  a_elems = '{32'd1, 32'd2, 32'd3, 32'd4};
  b_elems = '{32'd5, 32'd6, 32'd7, 32'd8};
  load_job();
  start_job();
  wait_ready();
  compare_results("2x2");
endtask

task automatic random_3x4_by_4x2();
  random_operands(3, 4, 2);
  load_job();
  start_job();
  wait_ready();
  compare_results("3x4x2");
endtask

task automatic outer_product();
  random_operands(3, 1, 3);
  load_job();
  start_job();
  wait_ready();
  compare_results("outer");
endtask

task automatic wraparound_product();
  rows_r  = 2;
  inner_k = 3;
  cols_c  = 2;
  a_elems.delete();
  b_elems.delete();
  repeat (6) a_elems.push_back(32'hffff_ffff - $urandom_range(0, 15));
  repeat (6) b_elems.push_back(32'hffff_ffff - $urandom_range(0, 15));
  load_job();
  start_job();
  wait_ready();
  compare_results("wrap");
endtask

task automatic back_to_back_jobs();
  int first_start;
  int total_writes;               // R x C of both jobs
  random_operands(2, 3, 3);
  total_writes = rows_r * cols_c;
  load_job();
  start_job();
  first_start = log_start;
  repeat (3) @(posedge clk);
  dut_valid <= 1'b1;                  // DUT is busy and ignores this
  @(posedge clk);
  dut_valid <= 1'b0;
  wait_ready();
  compare_results("first job");
  random_operands(3, 2, 2);
  total_writes += rows_r * cols_c;
  load_job();
  start_job();
  wait_ready();
  compare_results("second job");
  repeat (10) @(negedge clk);
  if (write_addr_log.size() - first_start != total_writes || dut_ready !== 1'b1) begin
    check_failed("extra job started by a dut_valid pulse while busy");
  end
endtask

`endif

// ==== verif/tb_matmul.sv ====
//--------------------------------------------------------------------------
// Testbench for the matrix-multiply engine. SRAM models cover the full
// 16-bit address space and answer a read one cycle after the address
//--------------------------------------------------------------------------
module tb_matmul import matmul_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          mem_depth      = 1 << addr_w;
  localparam int          timeout_cycles = 4000;  // All jobs together need a few hundred
  localparam logic [31:0] seed           = 32'hf22831d5;

  logic  clk;
  logic  reset_n;
  logic  dut_valid;
  logic  dut_ready;
  addr_t sram_input_read_address;
  addr_t sram_weight_read_address;
  data_t sram_input_read_data  = '0;
  data_t sram_weight_read_data = '0;
  logic  sram_result_write_enable;
  addr_t sram_result_write_address;
  data_t sram_result_write_data;

  data_t input_mem  [mem_depth];
  data_t weight_mem [mem_depth];
  data_t result_mem [mem_depth];
  addr_t write_addr_log [$];      // Every result write, in order
  int    err_count;
  int    cycle_count = 0;

  // Background word, different at every address
  function automatic data_t fill_word(input addr_t a);
    return {16'hc3a5 ^ a, a};
  endfunction

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //--------------------------------------------------------------------------
  // SRAM models

  always @(posedge clk) begin
    sram_input_read_data  <= input_mem[sram_input_read_address];
    sram_weight_read_data <= weight_mem[sram_weight_read_address];
  end

  always @(posedge clk) begin
    if (!reset_n) begin
      for (int i = 0; i < mem_depth; i++) begin
        result_mem[addr_t'(i)] <= fill_word(addr_t'(i));
      end
    end else if (sram_result_write_enable) begin
      result_mem[sram_result_write_address] <= sram_result_write_data;
      write_addr_log.push_back(sram_result_write_address);
    end
  end

  matmul_top dut (
    .clk                       (clk),
    .reset_n                   (reset_n),
    .dut_valid                 (dut_valid),
    .dut_ready                 (dut_ready),
    .sram_input_read_address   (sram_input_read_address),
    .sram_input_read_data      (sram_input_read_data),
    .sram_weight_read_address  (sram_weight_read_address),
    .sram_weight_read_data     (sram_weight_read_data),
    .sram_result_write_enable  (sram_result_write_enable),
    .sram_result_write_address (sram_result_write_address),
    .sram_result_write_data    (sram_result_write_data)
  );

  // Guard against a job that never returns dut_ready
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout after %0d cycles, the DUT never came back to idle", timeout_cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  `include "matmul_tests.svh"

  //--------------------------------------------------------------------------
  // Test sequence

  initial begin
    err_count = 0;
    reset_n   = 1'b0;
    dut_valid = 1'b0;
    void'($urandom(seed));
    for (int i = 0; i < mem_depth; i++) begin
      input_mem[addr_t'(i)]  = fill_word(addr_t'(i));
      weight_mem[addr_t'(i)] = ~fill_word(addr_t'(i));
    end
    repeat (2) @(posedge clk);
    reset_n <= 1'b1;

    idle_after_reset();
    fixed_2x2_product();
    random_3x4_by_4x2();
    outer_product();
    wraparound_product();
    back_to_back_jobs();

    repeat (2) @(posedge clk);
    $display("Run complete, %0d errors", err_count);
    if (err_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== design/matmul_top.sv ====
//--------------------------------------------------------------------------
// Matrix-multiply engine. All SRAMs answer a read one cycle after the
// address and never stall. Input and weight SRAMs are only read
//--------------------------------------------------------------------------
module matmul_top import matmul_pkg::*; (
  input  logic  clk,
  input  logic  reset_n,
  input  logic  dut_valid,
  output logic  dut_ready,

  // Input and weight SRAM read ports
  output addr_t sram_input_read_address,
  input  data_t sram_input_read_data,
  output addr_t sram_weight_read_address,
  input  data_t sram_weight_read_data,

  // Result SRAM write port
  output logic  sram_result_write_enable,
  output addr_t sram_result_write_address,
  output data_t sram_result_write_data
);

  logic header_read;
  logic dims_load;
  logic stream_en;
  logic job_last;
  logic operand_valid;
  logic elem_first;
  logic elem_last;

  //--------------------------------------------------------------------------
  // Job sequencing

  matmul_ctrl u_ctrl (
    .clk         (clk),
    .reset_n     (reset_n),
    .dut_valid   (dut_valid),
    .job_last    (job_last),
    .dut_ready   (dut_ready),
    .header_read (header_read),
    .dims_load   (dims_load),
    .stream_en   (stream_en)
  );

  // Dimensions, iterators and read addresses
  matmul_addr_gen u_addr_gen (
    .clk                 (clk),
    .reset_n             (reset_n),
    .header_read         (header_read),
    .dims_load           (dims_load),
    .stream_en           (stream_en),
    .input_read_data     (sram_input_read_data),
    .weight_read_data    (sram_weight_read_data),
    .input_read_address  (sram_input_read_address),
    .weight_read_address (sram_weight_read_address),
    .operand_valid       (operand_valid),
    .elem_first          (elem_first),
    .elem_last           (elem_last),
    .job_last            (job_last)
  );

  //--------------------------------------------------------------------------
  // Datapath, result address restarts on each header load

  matmul_mac u_mac (
    .clk                  (clk),
    .reset_n              (reset_n),
    .addr_clear           (dims_load),
    .operand_valid        (operand_valid),
    .elem_first           (elem_first),
    .elem_last            (elem_last),
    .input_read_data      (sram_input_read_data),
    .weight_read_data     (sram_weight_read_data),
    .result_write_enable  (sram_result_write_enable),
    .result_write_address (sram_result_write_address),
    .result_write_data    (sram_result_write_data)
  );

endmodule

// ==== design/matmul_mac.sv ====
//--------------------------------------------------------------------------
// MAC and result write. Sums are unsigned and wrap modulo 2^32
//--------------------------------------------------------------------------
module matmul_mac import matmul_pkg::*; (
  input  logic  clk,
  input  logic  reset_n,
  input  logic  addr_clear,
  input  logic  operand_valid,
  input  logic  elem_first,
  input  logic  elem_last,
  input  data_t input_read_data,
  input  data_t weight_read_data,
  output logic  result_write_enable,
  output addr_t result_write_address,
  output data_t result_write_data
);

  logic  valid_d;     // Aligned with SRAM read data
  logic  first_d;
  logic  last_d;
  logic  valid_q;     // Aligned with captured operands
  logic  first_q;
  logic  last_q;
  data_t input_q;
  data_t weight_q;
  data_t acc;
  data_t mac_sum;
  addr_t result_addr;

  //--------------------------------------------------------------------------
  // Strobe pipeline

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      valid_d <= 1'b0;
      first_d <= 1'b0;
      last_d  <= 1'b0;
      valid_q <= 1'b0;
      first_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      valid_d <= operand_valid;
      first_d <= elem_first;
      last_d  <= elem_last;
      valid_q <= valid_d;
      first_q <= first_d;
      last_q  <= last_d;
    end
  end

  // Operand capture
  always_ff @(posedge clk) begin
    if (valid_d) begin
      input_q  <= input_read_data;
      weight_q <= weight_read_data;
    end
  end

  //--------------------------------------------------------------------------
  // Multiply-accumulate, restarts from the product on an element's first step

  assign mac_sum = input_q * weight_q + (first_q ? data_t'(0) : acc);

  always_ff @(posedge clk) begin
    if (valid_q) begin
      acc <= mac_sum;
    end
  end

  // Row-major result address, back to 0 for each job
  always_ff @(posedge clk) begin
    if (!reset_n || addr_clear) begin
      result_addr <= '0;
    end else if (last_q) begin
      result_addr <= result_addr + 1'b1;
    end
  end

  assign result_write_enable  = last_q;
  assign result_write_address = result_addr;
  assign result_write_data    = mac_sum;    // Sum including the last product

endmodule

// ==== design/matmul_addr_gen.sv ====
//--------------------------------------------------------------------------
// Iterators and read addresses. All dimensions must be nonzero, and the
// weight row count is taken to equal K without a check
//--------------------------------------------------------------------------
module matmul_addr_gen import matmul_pkg::*; (
  input  logic  clk,
  input  logic  reset_n,
  input  logic  header_read,
  input  logic  dims_load,
  input  logic  stream_en,
  input  data_t input_read_data,
  input  data_t weight_read_data,
  output addr_t input_read_address,
  output addr_t weight_read_address,
  output logic  operand_valid,
  output logic  elem_first,
  output logic  elem_last,
  output logic  job_last
);

  header_t          input_hdr;
  header_t          weight_hdr;
  logic [dim_w-1:0] dim_rows;     // R
  logic [dim_w-1:0] dim_inner;    // K
  logic [dim_w-1:0] dim_cols;     // C
  logic [dim_w-1:0] inner_itr;
  logic [dim_w-1:0] col_itr;
  logic [dim_w-1:0] row_itr;
  addr_t            row_base;     // K times current row
  addr_t            input_addr;
  addr_t            weight_addr;
  logic             inner_wrap;
  logic             col_wrap;
  logic             row_wrap;

  assign input_hdr.raw  = input_read_data;
  assign weight_hdr.raw = weight_read_data;

  //--------------------------------------------------------------------------
  // Dimension registers, loaded from the two header words

  always_ff @(posedge clk) begin
    if (dims_load) begin
      dim_rows  <= input_hdr.dims.rows;
      dim_inner <= input_hdr.dims.cols;
      dim_cols  <= weight_hdr.dims.cols;
    end
  end

  assign inner_wrap = (inner_itr == dim_inner - 1'b1);
  assign col_wrap   = (col_itr == dim_cols - 1'b1);
  assign row_wrap   = (row_itr == dim_rows - 1'b1);

  //--------------------------------------------------------------------------
  // Iterators: inner every cycle, column on inner wrap, row on column wrap

  always_ff @(posedge clk) begin
    if (!reset_n || dims_load) begin
      inner_itr <= '0;
      col_itr   <= '0;
      row_itr   <= '0;
      row_base  <= '0;
    end else if (stream_en) begin
      if (inner_wrap) begin
        inner_itr <= '0;
        if (col_wrap) begin
          col_itr  <= '0;
          row_itr  <= row_itr + 1'b1;
          row_base <= row_base + addr_t'(dim_inner);
        end else begin
          col_itr <= col_itr + 1'b1;
        end
      end else begin
        inner_itr <= inner_itr + 1'b1;
      end
    end
  end

  //--------------------------------------------------------------------------
  // Read addresses, elements start at address 1 in both SRAMs

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      input_addr  <= '0;
      weight_addr <= '0;
    end else if (dims_load) begin
      input_addr  <= addr_t'(1);
      weight_addr <= addr_t'(1);
    end else if (stream_en) begin
      if (inner_wrap && col_wrap) begin
        input_addr  <= row_base + addr_t'(dim_inner) + 1'b1;  // Next row
        weight_addr <= addr_t'(1);                            // Back to column 0
      end else if (inner_wrap) begin
        input_addr  <= row_base + 1'b1;     // Same row again for next column
        weight_addr <= weight_addr + 1'b1;  // Columns are contiguous
      end else begin
        input_addr  <= input_addr + 1'b1;
        weight_addr <= weight_addr + 1'b1;
      end
    end
  end

  // Header read forces address 0
  assign input_read_address  = header_read ? '0 : input_addr;
  assign weight_read_address = header_read ? '0 : weight_addr;

  //--------------------------------------------------------------------------
  // Strobes for the MAC and the controller

  assign operand_valid = stream_en;
  assign elem_first    = stream_en && (inner_itr == '0);
  assign elem_last     = stream_en && inner_wrap;
  assign job_last      = stream_en && inner_wrap && col_wrap && row_wrap;

endmodule

// ==== design/matmul_ctrl.sv ====
//--------------------------------------------------------------------------
// Job FSM. dut_valid is only looked at in idle, a running job cannot abort
//--------------------------------------------------------------------------
module matmul_ctrl import matmul_pkg::*; (
  input  logic clk,
  input  logic reset_n,
  input  logic dut_valid,
  input  logic job_last,
  output logic dut_ready,
  output logic header_read,
  output logic dims_load,
  output logic stream_en
);

  ctrl_state_t state;
  ctrl_state_t next_state;
  logic [1:0]  drain_cnt;
  logic        drain_done;

  assign drain_done = (drain_cnt == 2'(drain_cycles - 1));

  //--------------------------------------------------------------------------
  // State register

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state <= st_idle;
    end else begin
      state <= next_state;
    end
  end

  //--------------------------------------------------------------------------
  // Next state

  always_comb begin
    next_state = state;
    case (state)
      st_idle: begin
        if (dut_valid) begin
          next_state = st_header;
        end
      end

      st_header: begin
        next_state = st_load;       // Header data comes back next cycle
      end

      st_load: begin
        next_state = st_stream;
      end

      st_stream: begin
        if (job_last) begin
          next_state = st_drain;    // Final pair already addressed
        end
      end

      st_drain: begin
        if (drain_done) begin
          next_state = st_idle;
        end
      end

      default: begin
        next_state = st_idle;
      end
    endcase
  end

  // Counts the drain cycles, sits at zero everywhere else
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      drain_cnt <= '0;
    end else if (state == st_drain) begin
      drain_cnt <= drain_cnt + 2'd1;
    end else begin
      drain_cnt <= '0;
    end
  end

  //--------------------------------------------------------------------------
  // Outputs

  // Ready follows the idle state, so it drops the cycle after dut_valid
  // and rises the cycle after the last result write
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      dut_ready <= 1'b1;
    end else begin
      dut_ready <= (next_state == st_idle);
    end
  end

  assign header_read = (state == st_header);
  assign dims_load   = (state == st_load);
  assign stream_en   = (state == st_stream);

endmodule

// ==== design/matmul_pkg.sv ====
//--------------------------------------------------------------------------
// Widths and types shared by the matrix-multiply engine
// Header fields are 16 bits wide, so each matrix side is at most 65535
//--------------------------------------------------------------------------
package matmul_pkg;

  //--------------------------------------------------------------------------
  // Widths

  localparam int data_w = 32;   // SRAM data word
  localparam int addr_w = 16;   // SRAM address
  localparam int dim_w  = 16;   // One dimension field of a header

  // Drain covers the SRAM read latency and the MAC write stage
  localparam int drain_cycles = 2;

  //--------------------------------------------------------------------------
  // Types

  typedef logic [data_w-1:0] data_t;
  typedef logic [addr_w-1:0] addr_t;

  // Header word at address 0 of the input and weight SRAMs
  typedef union packed {
    data_t raw;                   // Word as it comes off the SRAM
    struct packed {
      logic [dim_w-1:0] rows;     // Upper half
      logic [dim_w-1:0] cols;     // Lower half
    } dims;
  } header_t;

  // Job sequence of the controller
  typedef enum logic [2:0] {
    st_idle,
    st_header,    // Address 0 on both read ports
    st_load,      // Header words arrive
    st_stream,    // One operand pair per cycle
    st_drain      // Pipeline empties into the result SRAM
  } ctrl_state_t;

endpackage
